//--- axi_stream_writer.f
source/writer_pkg.sv
source/burst_plan_if.sv
source/beat_counter.sv
source/write_cmd_ctrl.sv
source/stream_fifo.sv
source/write_data_channel.sv
source/write_addr_channel.sv
source/write_resp_channel.sv
source/axi_stream_writer.sv
testbench/tb_axi_stream_writer.sv

//--- source/axi_stream_writer.sv
/*
 * AXI stream writer
 * Writes 32-bit words from an AXI4-Stream input to memory as
 * incrementing AXI4 bursts of up to 256 beats, started by a
 * command with address and byte size, with a done pulse at the end
 */
`timescale 1ns/100ps

module axi_stream_writer (
  input  logic                   aclk,
  input  logic                   areset,
  // Command
  input  logic                   ctrl_start,
  input  writer_pkg::addr_t      ctrl_addr_offset,
  input  writer_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  output logic                   ctrl_done,
  // AXI4 write master
  output logic                   awvalid,
  input  logic                   awready,
  output writer_pkg::addr_t      awaddr,
  output writer_pkg::burst_len_t awlen,
  output logic                   wvalid,
  input  logic                   wready,
  output writer_pkg::data_t      wdata,
  output writer_pkg::strb_t      wstrb,
  output logic                   wlast,
  input  logic                   bvalid,
  output logic                   bready,
  // AXI4-Stream slave
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  writer_pkg::data_t      s_axis_tdata
);

  writer_pkg::data_t fifo_data;
  logic              fifo_valid;
  logic              fifo_ready;
  logic              first_beat_seen;
  logic              aw_done;
  logic              aw_stall;
  logic              last_resp;

  burst_plan_if plan ();

  write_cmd_ctrl write_cmd_ctrl_inst (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size_in_bytes,
    .last_resp, .ctrl_done,
    .plan (plan.ctrl)
  );

  // Stream words wait here until the W channel runs
  stream_fifo stream_fifo_inst (
    .aclk, .areset,
    .wr_valid (s_axis_tvalid),
    .wr_ready (s_axis_tready),
    .wr_data  (s_axis_tdata),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready),
    .rd_data  (fifo_data)
  );

  write_data_channel write_data_channel_inst (
    .aclk, .areset,
    .plan (plan.chan),
    .fifo_valid, .fifo_ready, .fifo_data,
    .wvalid, .wready, .wdata, .wstrb, .wlast,
    .first_beat_seen
  );

  write_addr_channel write_addr_channel_inst (
    .aclk, .areset,
    .plan (plan.chan),
    .first_beat_seen, .aw_stall,
    .awvalid, .awready, .awaddr, .awlen,
    .aw_done
  );

  write_resp_channel write_resp_channel_inst (
    .aclk, .areset,
    .plan (plan.chan),
    .bvalid, .bready,
    .aw_done, .aw_stall, .last_resp
  );

endmodule

//--- source/beat_counter.sv
/*
 * Beat counter
 * Loadable up/down counter with a zero flag, used for the beat,
 * burst, pending-address and outstanding-response counts
 */
`timescale 1ns/100ps

module beat_counter #(
  parameter int unsigned     WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Simultaneous incr and decr cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  // Flag follows the present count, no extra register stage
  assign is_zero = (count == '0);

endmodule

//--- source/burst_plan_if.sv
/*
 * Burst plan interface
 * Decoded transfer parameters passed from command control
 * to the AW, W and B channel blocks
 */
`timescale 1ns/100ps

interface burst_plan_if;

  // One-cycle pulse, all fields below are stable by then
  logic                   start;
  // Number of bursts minus one
  writer_pkg::txn_count_t num_transactions;
  // Length of the last burst in awlen form
  writer_pkg::burst_len_t final_burst_len;
  // Byte enables of the very last beat
  writer_pkg::strb_t      final_strb;
  // Start address already aligned to a burst boundary
  writer_pkg::addr_t      addr_base;

  modport ctrl (output start, num_transactions, final_burst_len, final_strb, addr_base);
  modport chan (input start, num_transactions, final_burst_len, final_strb, addr_base);

endinterface

//--- source/stream_fifo.sv
/*
 * Stream FIFO
 * First-word-fall-through register FIFO between the stream input
 * and the W channel
 */
`timescale 1ns/100ps

module stream_fifo (
  input  logic              aclk,
  input  logic              areset,
  input  logic              wr_valid,
  output logic              wr_ready,
  input  writer_pkg::data_t wr_data,
  output logic              rd_valid,
  input  logic              rd_ready,
  output writer_pkg::data_t rd_data
);

  writer_pkg::data_t                             mem [writer_pkg::FIFO_DEPTH];
  logic [$clog2(writer_pkg::FIFO_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(writer_pkg::FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(writer_pkg::FIFO_DEPTH + 1)-1:0] count;
  logic                                          wr_fire;
  logic                                          rd_fire;

  assign wr_ready = (count != writer_pkg::FIFO_DEPTH);
  assign rd_valid = (count != '0);
  // Head word is presented without a read request
  assign rd_data  = mem[rd_ptr];
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  // Storage
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on their own at the power-of-two depth
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy stays between empty and the full depth
  // A write while full or a read while empty pushes it out of range
  assert property (@(posedge aclk) disable iff (areset)
    count <= writer_pkg::FIFO_DEPTH)
    else $error("stream FIFO occupancy out of range");

  // Pointer distance matches the occupancy
  assert property (@(posedge aclk) disable iff (areset)
    count[$clog2(writer_pkg::FIFO_DEPTH)-1:0] == wr_ptr - rd_ptr)
    else $error("stream FIFO pointers disagree with the occupancy");

endmodule

//--- source/write_addr_channel.sv
/*
 * AW channel
 * Issues one incrementing burst address per burst whose first
 * W beat has been seen, held back while too many bursts are
 * waiting for a response
 */
`timescale 1ns/100ps

module write_addr_channel (
  input  logic                   aclk,
  input  logic                   areset,
  burst_plan_if.chan             plan,
  input  logic                   first_beat_seen,
  input  logic                   aw_stall,
  output logic                   awvalid,
  input  logic                   awready,
  output writer_pkg::addr_t      awaddr,
  output writer_pkg::burst_len_t awlen,
  output logic                   aw_done
);

  writer_pkg::aw_state_t state;
  logic                  none_pending;
  logic                  final_burst;

  assign awvalid = (state == writer_pkg::aw_offer);
  assign aw_done = awvalid && awready;
  assign awlen   = final_burst ? plan.final_burst_len :
                                 writer_pkg::burst_len_t'(writer_pkg::BURST_BEATS - 1);

  // First beats on W not yet matched by an address
  beat_counter #(
    .WIDTH ($bits(writer_pkg::txn_count_t)),
    .INIT  ('0)
  ) pending_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (first_beat_seen),
    .decr       (aw_done),
    .load_value ('0),
    .count      (),
    .is_zero    (none_pending)
  );

  // Addresses still to issue in this transfer
  beat_counter #(
    .WIDTH ($bits(writer_pkg::txn_count_t)),
    .INIT  ('0)
  ) bursts_left_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (aw_done),
    .load_value (plan.num_transactions),
    .count      (),
    .is_zero    (final_burst)
  );

  //////////////////////////////
  // Offer FSM
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= writer_pkg::aw_wait;
    end else begin
      case (state)
        writer_pkg::aw_wait: begin
          if (!none_pending && !aw_stall) begin
            state <= writer_pkg::aw_offer;
          end
        end
        writer_pkg::aw_offer: begin
          // Held until the slave takes it
          if (awready) begin
            state <= writer_pkg::aw_wait;
          end
        end
        default: state <= writer_pkg::aw_wait;
      endcase
    end
  end

  // Next burst sits one burst size further on
  always_ff @(posedge aclk) begin
    if (plan.start) begin
      awaddr <= plan.addr_base;
    end else if (aw_done) begin
      awaddr <= awaddr + writer_pkg::BURST_BYTES;
    end
  end

  // AW payload must not change under back-pressure
  assert property (@(posedge aclk) disable iff (areset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("AW request dropped or changed before awready");

endmodule

//--- source/write_cmd_ctrl.sv
/*
 * Write command control
 * Captures a start address and byte size, rounds the size to beats,
 * splits it into full bursts plus a final burst, builds the last-beat
 * strobe and pulses done after the final write response
 */
`timescale 1ns/100ps

module write_cmd_ctrl (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  writer_pkg::addr_t      ctrl_addr_offset,
  input  writer_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  input  logic                   last_resp,
  output logic                   ctrl_done,
  burst_plan_if.ctrl             plan
);

  writer_pkg::cmd_state_t                 state;
  logic                                   accept;
  logic                                   start_d1;
  logic [writer_pkg::LOG_DW_BYTES-1:0]    byte_rem;
  // Total beats minus one
  logic [writer_pkg::TOTAL_LEN_WIDTH-1:0] total_len;

  // Commands are only taken while idle
  assign accept   = ctrl_start && (state == writer_pkg::cmd_idle);
  assign byte_rem = ctrl_xfer_size_in_bytes[writer_pkg::LOG_DW_BYTES-1:0];

  //////////////////////////////
  // Busy tracking and done
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      state     <= writer_pkg::cmd_idle;
      start_d1  <= 1'b0;
      plan.start <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      if (accept) begin
        state <= writer_pkg::cmd_busy;
      end else if (last_resp) begin
        state <= writer_pkg::cmd_idle;
      end
      // Start reaches the channels two cycles after the command
      start_d1   <= accept;
      plan.start <= start_d1;
      ctrl_done  <= last_resp;
    end
  end

  //////////////////////////////
  // Command capture
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (accept) begin
      // Round up to whole beats in length-minus-one form
      if (byte_rem != '0) begin
        total_len <= ctrl_xfer_size_in_bytes[writer_pkg::LOG_DW_BYTES +:
                                             writer_pkg::TOTAL_LEN_WIDTH];
      end else begin
        total_len <= ctrl_xfer_size_in_bytes[writer_pkg::LOG_DW_BYTES +:
                                             writer_pkg::TOTAL_LEN_WIDTH] - 1'b1;
      end
      // Force the start onto a burst boundary
      plan.addr_base <= ctrl_addr_offset &
                        ~writer_pkg::addr_t'(writer_pkg::BURST_BYTES - 1);
      // Byte i valid below the remainder, whole word when it divides evenly
      for (int i = 0; i < writer_pkg::DW_BYTES; i++) begin
        plan.final_strb[i] <= (byte_rem == '0) || (i < byte_rem);
      end
    end
  end

  // Upper bits count bursts, lower bits give the final burst length
  assign plan.num_transactions = total_len[writer_pkg::LOG_BURST_BEATS +:
                                           $bits(writer_pkg::txn_count_t)];
  assign plan.final_burst_len  = total_len[writer_pkg::LOG_BURST_BEATS-1:0];

  // A second command must wait for done of the first
  assert property (@(posedge aclk) disable iff (areset)
    (state == writer_pkg::cmd_busy) |-> !ctrl_start)
    else $error("ctrl_start raised while a transfer is in progress");

endmodule

//--- source/write_data_channel.sv
/*
 * W channel
 * Moves FIFO words onto W while a transfer runs, counts beats
 * and bursts for wlast, applies the final strobe and flags the
 * first beat of every burst to the address channel
 */
`timescale 1ns/100ps

module write_data_channel (
  input  logic              aclk,
  input  logic              areset,
  burst_plan_if.chan        plan,
  input  logic              fifo_valid,
  output logic              fifo_ready,
  input  writer_pkg::data_t fifo_data,
  output logic              wvalid,
  input  logic              wready,
  output writer_pkg::data_t wdata,
  output writer_pkg::strb_t wstrb,
  output logic              wlast,
  output logic              first_beat_seen
);

  writer_pkg::txn_count_t bursts_left;
  writer_pkg::burst_len_t beats_load_value;
  logic                   running;
  logic                   wfire;
  logic                   final_burst;
  logic                   almost_final;
  logic                   single_burst;
  logic                   load_beats;
  logic                   wfirst;
  logic                   first_marked;
  logic                   first_pending;

  //////////////////////////////
  // Beat flow
  //////////////////////////////
  // Nothing leaves the FIFO before the plan is known
  assign wvalid     = fifo_valid && running;
  assign fifo_ready = wready && running;
  assign wdata      = fifo_data;
  assign wfire      = wvalid && wready;
  assign wstrb      = (wlast && final_burst) ? plan.final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (plan.start) begin
      running <= 1'b1;
    end else if (wfire && wlast && final_burst) begin
      running <= 1'b0;
    end
  end

  //////////////////////////////
  // Beat and burst counting
  //////////////////////////////
  assign single_burst = (plan.num_transactions == '0);
  assign almost_final = (bursts_left == writer_pkg::txn_count_t'(1));
  // Full bursts wrap from 0 to 255 alone, the short one is loaded
  assign load_beats       = plan.start || (wfire && wlast && almost_final);
  assign beats_load_value = (plan.start && !single_burst) ?
                            writer_pkg::burst_len_t'(writer_pkg::BURST_BEATS - 1) :
                            plan.final_burst_len;

  beat_counter #(
    .WIDTH ($bits(writer_pkg::burst_len_t)),
    .INIT  (writer_pkg::burst_len_t'(writer_pkg::BURST_BEATS - 1))
  ) beats_left_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wfire),
    .load_value (beats_load_value),
    .count      (),
    .is_zero    (wlast)
  );

  beat_counter #(
    .WIDTH ($bits(writer_pkg::txn_count_t)),
    .INIT  ('0)
  ) bursts_left_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (wfire && wlast),
    .load_value (plan.num_transactions),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  //////////////////////////////
  // First beat detection
  //////////////////////////////
  // Marked once seen so a stalled first beat gives one pulse
  assign first_pending = wvalid && wfirst && !first_marked;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst          <= 1'b1;
      first_marked    <= 1'b0;
      first_beat_seen <= 1'b0;
    end else begin
      if (wfire) begin
        wfirst <= wlast;
      end
      if (wfire) begin
        first_marked <= 1'b0;
      end else if (first_pending) begin
        first_marked <= 1'b1;
      end
      first_beat_seen <= first_pending;
    end
  end

endmodule

//--- source/write_resp_channel.sv
/*
 * B channel
 * Accepts write responses, tracks the outstanding-burst vacancy
 * that stalls the AW channel and flags the final response
 */
`timescale 1ns/100ps

module write_resp_channel (
  input  logic       aclk,
  input  logic       areset,
  burst_plan_if.chan plan,
  input  logic       bvalid,
  output logic       bready,
  input  logic       aw_done,
  output logic       aw_stall,
  output logic       last_resp
);

  writer_pkg::outstanding_t vacancy;
  logic                     bfire;
  logic                     final_resp;

  // Responses are always taken, the code is not checked
  assign bready    = 1'b1;
  assign bfire     = bvalid && bready;
  assign last_resp = bfire && final_resp;

  // Free slots for bursts awaiting a response
  beat_counter #(
    .WIDTH ($bits(writer_pkg::outstanding_t)),
    .INIT  (writer_pkg::outstanding_t'(writer_pkg::MAX_OUTSTANDING))
  ) vacancy_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bfire),
    .decr       (aw_done),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (aw_stall)
  );

  // Responses still expected in this transfer
  beat_counter #(
    .WIDTH ($bits(writer_pkg::txn_count_t)),
    .INIT  ('0)
  ) resp_left_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (bfire),
    .load_value (plan.num_transactions),
    .count      (),
    .is_zero    (final_resp)
  );

  // Every response needs an earlier AW handshake
  assert property (@(posedge aclk) disable iff (areset)
    vacancy <= writer_pkg::MAX_OUTSTANDING)
    else $error("write response without an outstanding burst");

endmodule

//--- source/writer_pkg.sv
/*
 * Stream writer package
 * Widths, AXI burst constants, payload types and FSM encodings
 * shared by every block of the stream-to-memory write master
 */

package writer_pkg;

  //////////////////////////////
  // Widths and burst constants
  //////////////////////////////
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned DATA_WIDTH      = 32;
  localparam int unsigned DW_BYTES        = DATA_WIDTH / 8;
  localparam int unsigned XFER_SIZE_WIDTH = 32;
  // 256 beats of 4 bytes, well inside the 4 KB AXI boundary
  localparam int unsigned BURST_BEATS     = 256;
  localparam int unsigned BURST_BYTES     = BURST_BEATS * DW_BYTES;
  localparam int unsigned MAX_OUTSTANDING = 32;
  localparam int unsigned FIFO_DEPTH      = 32;

  // Derived bit positions inside a byte size
  localparam int unsigned LOG_DW_BYTES    = $clog2(DW_BYTES);
  localparam int unsigned LOG_BURST_BEATS = $clog2(BURST_BEATS);
  localparam int unsigned TOTAL_LEN_WIDTH = XFER_SIZE_WIDTH - LOG_DW_BYTES;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [DW_BYTES-1:0]        strb_t;
  typedef logic [XFER_SIZE_WIDTH-1:0] xfer_size_t;
  // Beats minus one, as carried on awlen
  typedef logic [LOG_BURST_BEATS-1:0] burst_len_t;
  // Bursts after the first one
  typedef logic [TOTAL_LEN_WIDTH-LOG_BURST_BEATS-1:0] txn_count_t;
  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0]       outstanding_t;

  typedef enum logic {cmd_idle, cmd_busy} cmd_state_t;
  typedef enum logic {aw_wait, aw_offer} aw_state_t;

endpackage

//--- testbench/tb_axi_stream_writer.sv
/*
 * Testbench for the AXI stream writer
 * Stream source, AXI4 write slave model with random back-pressure,
 * a scoreboard of expected AW and W values and concurrent checks
 */
`timescale 1ns/100ps

module tb_axi_stream_writer;

  logic                   aclk = 1'b0;
  logic                   areset;
  logic                   ctrl_start;
  writer_pkg::addr_t      ctrl_addr_offset;
  writer_pkg::xfer_size_t ctrl_xfer_size_in_bytes;
  logic                   ctrl_done;
  logic                   awvalid;
  logic                   awready = 1'b0;
  writer_pkg::addr_t      awaddr;
  writer_pkg::burst_len_t awlen;
  logic                   wvalid;
  logic                   wready = 1'b0;
  writer_pkg::data_t      wdata;
  writer_pkg::strb_t      wstrb;
  logic                   wlast;
  logic                   bvalid = 1'b0;
  logic                   bready;
  logic                   s_axis_tvalid = 1'b0;
  logic                   s_axis_tready;
  writer_pkg::data_t      s_axis_tdata = '0;

  // Test control, written by the test sequence on the clock edge
  logic                   stress = 1'b0;
  logic                   b_hold = 1'b0;
  writer_pkg::addr_t      cur_offset = '0;
  int                     cur_size = 0;
  int                     aw_base = 0;
  int                     w_base = 0;
  int                     b_base = 0;
  int                     stream_target = 0;
  // Slave model and stream source counters
  int                     stream_sent = 0;
  int                     aw_count = 0;
  int                     w_total = 0;
  int                     w_in_burst = 0;
  int                     wlast_count = 0;
  int                     b_count = 0;
  logic [31:0]            rnd = 32'h655c3d57;
  // Bookkeeping
  int                     error_count = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  logic                   timed_out = 1'b0;

  always #4 aclk = ~aclk;

  axi_stream_writer axi_stream_writer_inst (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Incrementing pattern, offset so that zero never looks valid
  function automatic writer_pkg::data_t stream_word(input int index);
    return writer_pkg::data_t'(32'h5a00_0000 + index);
  endfunction

  //////////////////////////////
  // Scoreboard expectations
  //////////////////////////////
  int                     total_beats;
  int                     num_bursts;
  int                     aw_idx;
  int                     w_idx;
  int                     size_rem;
  writer_pkg::addr_t      exp_awaddr;
  writer_pkg::burst_len_t exp_awlen;
  writer_pkg::data_t      exp_wdata;
  writer_pkg::strb_t      exp_wstrb;
  logic                   exp_wlast;
  logic                   final_b;

  assign total_beats = (cur_size + writer_pkg::DW_BYTES - 1) / writer_pkg::DW_BYTES;
  assign num_bursts  = (total_beats + writer_pkg::BURST_BEATS - 1) / writer_pkg::BURST_BEATS;
  assign aw_idx      = aw_count - aw_base;
  assign w_idx       = w_total - w_base;
  assign size_rem    = cur_size % writer_pkg::DW_BYTES;
  // Aligned down to the burst boundary, one burst size per AW
  assign exp_awaddr  = cur_offset - cur_offset % writer_pkg::BURST_BYTES +
                       aw_idx * writer_pkg::BURST_BYTES;
  assign exp_awlen   = writer_pkg::burst_len_t'((aw_idx == num_bursts - 1) ?
                       total_beats - 1 - (num_bursts - 1) * writer_pkg::BURST_BEATS :
                       writer_pkg::BURST_BEATS - 1);
  assign exp_wdata   = stream_word(w_total);
  assign exp_wlast   = ((w_idx + 1) % writer_pkg::BURST_BEATS == 0) ||
                       (w_idx == total_beats - 1);
  assign final_b     = bvalid && bready && (b_count - b_base == num_bursts - 1);

  always_comb begin
    for (int i = 0; i < writer_pkg::DW_BYTES; i++) begin
      exp_wstrb[i] = (w_idx != total_beats - 1) || (size_rem == 0) || (i < size_rem);
    end
  end

  //////////////////////////////
  // Stimulus and slave model
  //////////////////////////////
  always @(posedge aclk) begin
    rnd <= lcg_step(rnd);
  end

  // Stream source, payload held until tready
  always @(posedge aclk) begin : stream_source
    int next_word;
    next_word = stream_sent + ((s_axis_tvalid && s_axis_tready) ? 1 : 0);
    if (areset) begin
      s_axis_tvalid <= 1'b0;
    end else begin
      stream_sent <= next_word;
      if (!s_axis_tvalid || s_axis_tready) begin
        if (next_word < stream_target && (!stress || rnd[31:30] != 2'b00)) begin
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= stream_word(next_word);
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
    end
  end

  // Ready gaps on AW and W
  always @(posedge aclk) begin
    if (areset) begin
      wready  <= 1'b0;
      awready <= 1'b0;
    end else begin
      wready  <= !stress || (rnd[29:28] != 2'b00);
      awready <= !stress || (rnd[27:26] != 2'b00);
    end
  end

  // Handshake counters of the slave model
  always @(posedge aclk) begin
    if (!areset) begin
      if (awvalid && awready) begin
        aw_count <= aw_count + 1;
      end
      if (wvalid && wready) begin
        w_total    <= w_total + 1;
        w_in_burst <= wlast ? 0 : w_in_burst + 1;
        if (wlast) begin
          wlast_count <= wlast_count + 1;
        end
      end
    end
  end

  // One response per burst once both its AW and its wlast went through
  always @(posedge aclk) begin : resp_driver
    int answered;
    int complete;
    answered = b_count + ((bvalid && bready) ? 1 : 0);
    complete = (aw_count < wlast_count) ? aw_count : wlast_count;
    if (areset) begin
      bvalid <= 1'b0;
    end else begin
      if (bvalid && bready) begin
        b_count <= b_count + 1;
      end
      if (!bvalid || bready) begin
        bvalid <= !b_hold && (complete > answered) && (!stress || rnd[25:24] != 2'b00);
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  assert property (@(posedge aclk) areset |=> !awvalid && !wvalid && !ctrl_done && s_axis_tready)
    else begin
      $display("Outputs not in their idle state after reset at time %0t", $time);
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) awvalid && awready |-> awaddr == exp_awaddr)
    else begin
      $display("MISMATCH time=%0t awaddr expected=%h actual=%h", $time,
               $sampled(exp_awaddr), $sampled(awaddr));
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) awvalid && awready |-> awlen == exp_awlen)
    else begin
      $display("MISMATCH time=%0t awlen expected=%0d actual=%0d", $time,
               $sampled(exp_awlen), $sampled(awlen));
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) wvalid && wready |-> wdata == exp_wdata)
    else begin
      $display("MISMATCH time=%0t wdata expected=%h actual=%h", $time,
               $sampled(exp_wdata), $sampled(wdata));
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) wvalid && wready |-> wstrb == exp_wstrb)
    else begin
      $display("MISMATCH time=%0t wstrb expected=%b actual=%b", $time,
               $sampled(exp_wstrb), $sampled(wstrb));
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) wvalid && wready |-> wlast == exp_wlast)
    else begin
      $display("MISMATCH time=%0t wlast expected=%b actual=%b", $time,
               $sampled(exp_wlast), $sampled(wlast));
      error_count++;
    end

  // Responses are never back-pressured
  assert property (@(posedge aclk) disable iff (areset) bready)
    else begin
      $display("MISMATCH time=%0t bready expected=1 actual=%b", $time, $sampled(bready));
      error_count++;
    end

  // A burst counts as started once its first beat is valid on W
  assert property (@(posedge aclk) disable iff (areset)
    aw_count + ((awvalid && awready) ? 1 : 0) <=
    wlast_count + ((w_in_burst != 0 || wvalid) ? 1 : 0))
    else begin
      $display("AW handshake came before the first W beat of its burst at time %0t", $time);
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset)
    aw_count - b_count <= writer_pkg::MAX_OUTSTANDING)
    else begin
      $display("More than the allowed bursts outstanding at time %0t", $time);
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) final_b |=> ctrl_done)
    else begin
      $display("ctrl_done missing after the final write response at time %0t", $time);
      error_count++;
    end

  assert property (@(posedge aclk) disable iff (areset) ctrl_done |-> $past(final_b))
    else begin
      $display("ctrl_done pulsed at an unexpected time %0t", $time);
      error_count++;
    end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count != errors_before || timed_out) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic run_transfer(input string name, input writer_pkg::addr_t offset,
                              input int size, input logic stress_on, input logic hold_resp);
    int errors_before;
    int beats;
    int bursts;
    int cycles;
    errors_before = error_count;
    beats  = (size + writer_pkg::DW_BYTES - 1) / writer_pkg::DW_BYTES;
    bursts = (beats + writer_pkg::BURST_BEATS - 1) / writer_pkg::BURST_BEATS;
    @(posedge aclk);
    stress                  <= stress_on;
    b_hold                  <= hold_resp;
    cur_offset              <= offset;
    cur_size                <= size;
    aw_base                 <= aw_count;
    w_base                  <= w_total;
    b_base                  <= b_count;
    stream_target           <= stream_target + beats;
    ctrl_start              <= 1'b1;
    ctrl_addr_offset        <= offset;
    ctrl_xfer_size_in_bytes <= size;
    @(posedge aclk);
    ctrl_start <= 1'b0;
    // Responses stay off until the AW channel sits at its limit
    if (hold_resp) begin
      cycles = 0;
      while (!timed_out && !(aw_count - b_count == writer_pkg::MAX_OUTSTANDING &&
                             w_total - w_base == beats)) begin
        @(posedge aclk);
        cycles++;
        if (cycles > 100000) begin
          $display("Timeout in %s, outstanding bursts never reached the limit", name);
          timed_out = 1'b1;
        end
      end
      b_hold <= 1'b0;
    end
    cycles = 0;
    while (!timed_out && !ctrl_done) begin
      @(posedge aclk);
      cycles++;
      if (cycles > 200000) begin
        $display("Timeout in %s, ctrl_done never came", name);
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      assert (aw_count - aw_base == bursts)
        else begin
          $display("MISMATCH time=%0t aw_count expected=%0d actual=%0d", $time,
                   bursts, aw_count - aw_base);
          error_count++;
        end
      assert (w_total - w_base == beats)
        else begin
          $display("MISMATCH time=%0t w_beats expected=%0d actual=%0d", $time,
                   beats, w_total - w_base);
          error_count++;
        end
    end
    @(posedge aclk);
    report_test(name, errors_before);
  endtask

  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    repeat (16) @(posedge aclk);
    areset <= 1'b0;
    repeat (2) @(posedge aclk);
    report_test("after_reset", 0);
    run_transfer("short_transfer", 32'h0000_1234, 10, 1'b0, 1'b0);
    if (!timed_out) begin
      run_transfer("multi_burst", 32'h0002_08c4, 2600, 1'b1, 1'b0);
    end
    if (!timed_out) begin
      run_transfer("outstanding_limit", 32'h0010_0000,
                   40 * writer_pkg::BURST_BYTES, 1'b0, 1'b1);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0 && tests_failed == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
